//--- src/oxi_pkg.sv
package oxi_pkg;

    // sample and setting widths
    typedef logic [7:0]  adc_t;
    typedef logic [6:0]  dc_comp_t;
    typedef logic [3:0]  pga_gain_t;

    // 27 full-scale samples still fit in 13 bits
    typedef logic [12:0] adc_sum_t;
    typedef logic [4:0]  win_count_t;
    typedef logic [3:0]  slot_count_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DC_RED,
        GAIN_RED,
        DC_IR,
        GAIN_IR,
        OPERATE
    } calib_state_t;

    // statistics window
    localparam int        WINDOW_LEN     = 27;

    // dc search
    localparam dc_comp_t  DC_INIT        = 7'd44;
    localparam adc_t      AVG_LOW        = 8'd120;
    localparam adc_t      AVG_HIGH       = 8'd135;
    localparam int        DC_MAX_WINDOWS = 16;

    // gain search
    localparam adc_t      CLIP_LO        = 8'd10;
    localparam adc_t      CLIP_HI        = 8'd245;
    localparam pga_gain_t PGA_MAX        = 4'd15;

    // operation slots
    localparam int        SLOT_LEN       = 10;

endpackage

//--- src/window_stats.sv
module window_stats (
    input  logic          CLK,
    input  logic          rst_n,
    input  logic          win_run,
    input  oxi_pkg::adc_t adc,
    output logic          win_done,
    output oxi_pkg::adc_t win_avg,
    output oxi_pkg::adc_t win_min,
    output oxi_pkg::adc_t win_max
);

    oxi_pkg::win_count_t count;
    oxi_pkg::adc_sum_t   sum;
    oxi_pkg::adc_t       run_min;
    oxi_pkg::adc_t       run_max;

    oxi_pkg::adc_sum_t   sum_next;
    oxi_pkg::adc_t       min_next;
    oxi_pkg::adc_t       max_next;
    logic                last_sample;

    // running values including the current sample
    always_comb begin
        sum_next    = sum + oxi_pkg::adc_sum_t'(adc);
        min_next    = (adc < run_min) ? adc : run_min;
        max_next    = (adc > run_max) ? adc : run_max;
        last_sample = (count == oxi_pkg::win_count_t'(oxi_pkg::WINDOW_LEN - 1));
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            sum      <= '0;
            run_min  <= '1;
            run_max  <= '0;
            win_done <= 1'b0;
        end else if (!win_run) begin
            count    <= '0;
            sum      <= '0;
            run_min  <= '1;
            run_max  <= '0;
            win_done <= 1'b0;
        end else if (last_sample) begin
            // next window starts with the very next sample
            count    <= '0;
            sum      <= '0;
            run_min  <= '1;
            run_max  <= '0;
            win_done <= 1'b1;
        end else begin
            count    <= count + 1'b1;
            sum      <= sum_next;
            run_min  <= min_next;
            run_max  <= max_next;
            win_done <= 1'b0;
        end
    end

    // results held until the next window closes
    always_ff @(posedge CLK) begin
        if (win_run && last_sample) begin
            win_avg <= oxi_pkg::adc_t'(sum_next / oxi_pkg::WINDOW_LEN);
            win_min <= min_next;
            win_max <= max_next;
        end
    end

endmodule

//--- src/calib_fsm.sv
module calib_fsm (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               find_setting,
    input  logic               win_done,
    input  oxi_pkg::adc_t      win_avg,
    input  oxi_pkg::adc_t      win_min,
    input  oxi_pkg::adc_t      win_max,
    output logic               win_run,
    output logic               trial_led_red,
    output logic               trial_led_ir,
    output oxi_pkg::dc_comp_t  trial_dc,
    output oxi_pkg::pga_gain_t trial_gain,
    output oxi_pkg::dc_comp_t  red_dc,
    output oxi_pkg::pga_gain_t red_gain,
    output oxi_pkg::dc_comp_t  ir_dc,
    output oxi_pkg::pga_gain_t ir_gain,
    output logic               calib_done
);

    oxi_pkg::calib_state_t state;

    // windows already spent in the current dc search
    logic [3:0]            dc_windows;

    logic [7:0]            dc_raised;
    oxi_pkg::dc_comp_t     dc_up;
    oxi_pkg::dc_comp_t     dc_down;
    logic                  dc_in_band;
    logic                  dc_lock;
    logic                  unclipped;
    logic                  gain_lock;
    oxi_pkg::pga_gain_t    gain_lock_val;

    // statistics only run in the four search states
    assign win_run = (state == oxi_pkg::DC_RED)   || (state == oxi_pkg::GAIN_RED) ||
                     (state == oxi_pkg::DC_IR)    || (state == oxi_pkg::GAIN_IR);

    // search step decisions from the finished window
    always_comb begin
        dc_raised  = {1'b0, trial_dc} + {2'b00, trial_dc[6:1]};
        dc_up      = dc_raised[7] ? 7'd127 : dc_raised[6:0];
        dc_down    = trial_dc - {1'b0, trial_dc[6:1]};
        dc_in_band = (win_avg >= oxi_pkg::AVG_LOW) && (win_avg <= oxi_pkg::AVG_HIGH);
        // halving stalls at 1, so the search is capped
        dc_lock    = dc_in_band ||
                     (dc_windows == 4'(oxi_pkg::DC_MAX_WINDOWS - 1));

        unclipped  = (win_min > oxi_pkg::CLIP_LO) && (win_max < oxi_pkg::CLIP_HI);
        gain_lock  = !unclipped || (trial_gain == oxi_pkg::PGA_MAX);
        if (!unclipped) begin
            // back off one step from the clipping gain
            gain_lock_val = (trial_gain == '0) ? '0 : trial_gain - 1'b1;
        end else begin
            gain_lock_val = trial_gain;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state         <= oxi_pkg::IDLE;
            dc_windows    <= '0;
            trial_led_red <= 1'b0;
            trial_led_ir  <= 1'b0;
            trial_dc      <= '0;
            trial_gain    <= '0;
            red_dc        <= '0;
            red_gain      <= '0;
            ir_dc         <= '0;
            ir_gain       <= '0;
            calib_done    <= 1'b0;
        end else if (find_setting) begin
            // restart from any state
            state         <= oxi_pkg::START;
            dc_windows    <= '0;
            trial_led_red <= 1'b0;
            trial_led_ir  <= 1'b0;
            trial_dc      <= oxi_pkg::DC_INIT;
            trial_gain    <= '0;
            calib_done    <= 1'b0;
        end else begin
            case (state)
                oxi_pkg::START: begin
                    state         <= oxi_pkg::DC_RED;
                    trial_led_red <= 1'b1;
                end

                oxi_pkg::DC_RED, oxi_pkg::DC_IR: begin
                    if (win_done) begin
                        if (dc_lock) begin
                            if (state == oxi_pkg::DC_RED) begin
                                red_dc <= trial_dc;
                                state  <= oxi_pkg::GAIN_RED;
                            end else begin
                                ir_dc  <= trial_dc;
                                state  <= oxi_pkg::GAIN_IR;
                            end
                            trial_gain <= '0;
                            dc_windows <= '0;
                        end else begin
                            trial_dc   <= (win_avg < oxi_pkg::AVG_LOW) ? dc_down : dc_up;
                            dc_windows <= dc_windows + 1'b1;
                        end
                    end
                end

                oxi_pkg::GAIN_RED, oxi_pkg::GAIN_IR: begin
                    if (win_done) begin
                        if (!gain_lock) begin
                            trial_gain <= trial_gain + 1'b1;
                        end else if (state == oxi_pkg::GAIN_RED) begin
                            // hand over to the ir channel
                            red_gain      <= gain_lock_val;
                            state         <= oxi_pkg::DC_IR;
                            trial_dc      <= oxi_pkg::DC_INIT;
                            trial_gain    <= '0;
                            trial_led_red <= 1'b0;
                            trial_led_ir  <= 1'b1;
                        end else begin
                            ir_gain       <= gain_lock_val;
                            state         <= oxi_pkg::OPERATE;
                            trial_gain    <= '0;
                            trial_led_ir  <= 1'b0;
                            calib_done    <= 1'b1;
                        end
                    end
                end

                // wait for find_setting
                oxi_pkg::IDLE, oxi_pkg::OPERATE: begin
                    state <= state;
                end

                default: begin
                    state <= oxi_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/led_sequencer.sv
module led_sequencer (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               calib_done,
    input  logic               trial_led_red,
    input  logic               trial_led_ir,
    input  oxi_pkg::dc_comp_t  trial_dc,
    input  oxi_pkg::pga_gain_t trial_gain,
    input  oxi_pkg::dc_comp_t  red_dc,
    input  oxi_pkg::pga_gain_t red_gain,
    input  oxi_pkg::dc_comp_t  ir_dc,
    input  oxi_pkg::pga_gain_t ir_gain,
    input  oxi_pkg::adc_t      adc,
    output logic               led_red,
    output logic               led_ir,
    output oxi_pkg::dc_comp_t  dc_comp,
    output oxi_pkg::pga_gain_t pga_gain,
    output oxi_pkg::adc_t      red_adc_value,
    output oxi_pkg::adc_t      ir_adc_value
);

    // slot position of the cycle the outputs currently show
    oxi_pkg::slot_count_t slot_cnt;
    logic                 ir_slot;
    logic                 op_active;

    logic                 slot_last;
    logic                 next_ir;
    oxi_pkg::slot_count_t next_cnt;

    always_comb begin
        slot_last = (slot_cnt == oxi_pkg::slot_count_t'(oxi_pkg::SLOT_LEN - 1));
        // first operating cycle always opens a red slot
        next_ir   = op_active ? (ir_slot ^ slot_last) : 1'b0;
        next_cnt  = (op_active && !slot_last) ? slot_cnt + 1'b1 : '0;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt      <= '0;
            ir_slot       <= 1'b0;
            op_active     <= 1'b0;
            led_red       <= 1'b0;
            led_ir        <= 1'b0;
            dc_comp       <= '0;
            pga_gain      <= '0;
            red_adc_value <= '0;
            ir_adc_value  <= '0;
        end else begin
            op_active <= calib_done;

            // capture at the last cycle of a running slot
            if (op_active && slot_last) begin
                if (ir_slot) begin
                    ir_adc_value  <= adc;
                end else begin
                    red_adc_value <= adc;
                end
            end

            if (!calib_done) begin
                slot_cnt <= '0;
                ir_slot  <= 1'b0;
                led_red  <= trial_led_red;
                led_ir   <= trial_led_ir;
                dc_comp  <= trial_dc;
                pga_gain <= trial_gain;
            end else begin
                slot_cnt <= next_cnt;
                ir_slot  <= next_ir;
                led_red  <= !next_ir;
                led_ir   <= next_ir;
                dc_comp  <= next_ir ? ir_dc : red_dc;
                pga_gain <= next_ir ? ir_gain : red_gain;
            end
        end
    end

endmodule

//--- src/oxi_controller.sv
module oxi_controller (
    input  logic               CLK,
    input  logic               rst_n,
    input  oxi_pkg::adc_t      adc,
    input  logic               find_setting,
    output logic               led_red,
    output logic               led_ir,
    output oxi_pkg::dc_comp_t  dc_comp,
    output oxi_pkg::pga_gain_t pga_gain,
    output oxi_pkg::adc_t      red_adc_value,
    output oxi_pkg::adc_t      ir_adc_value,
    output logic               calib_done
);

    logic               win_run;
    logic               win_done;
    oxi_pkg::adc_t      win_avg;
    oxi_pkg::adc_t      win_min;
    oxi_pkg::adc_t      win_max;

    logic               trial_led_red;
    logic               trial_led_ir;
    oxi_pkg::dc_comp_t  trial_dc;
    oxi_pkg::pga_gain_t trial_gain;
    oxi_pkg::dc_comp_t  red_dc;
    oxi_pkg::pga_gain_t red_gain;
    oxi_pkg::dc_comp_t  ir_dc;
    oxi_pkg::pga_gain_t ir_gain;

    window_stats u_window_stats (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .win_run  (win_run),
        .adc      (adc),
        .win_done (win_done),
        .win_avg  (win_avg),
        .win_min  (win_min),
        .win_max  (win_max)
    );

    calib_fsm u_calib_fsm (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .find_setting  (find_setting),
        .win_done      (win_done),
        .win_avg       (win_avg),
        .win_min       (win_min),
        .win_max       (win_max),
        .win_run       (win_run),
        .trial_led_red (trial_led_red),
        .trial_led_ir  (trial_led_ir),
        .trial_dc      (trial_dc),
        .trial_gain    (trial_gain),
        .red_dc        (red_dc),
        .red_gain      (red_gain),
        .ir_dc         (ir_dc),
        .ir_gain       (ir_gain),
        .calib_done    (calib_done)
    );

    // outputs lag calib_fsm by one register stage
    led_sequencer u_led_sequencer (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .calib_done    (calib_done),
        .trial_led_red (trial_led_red),
        .trial_led_ir  (trial_led_ir),
        .trial_dc      (trial_dc),
        .trial_gain    (trial_gain),
        .red_dc        (red_dc),
        .red_gain      (red_gain),
        .ir_dc         (ir_dc),
        .ir_gain       (ir_gain),
        .adc           (adc),
        .led_red       (led_red),
        .led_ir        (led_ir),
        .dc_comp       (dc_comp),
        .pga_gain      (pga_gain),
        .red_adc_value (red_adc_value),
        .ir_adc_value  (ir_adc_value)
    );

endmodule

//--- dv/oxi_chk.sv
module oxi_chk (
    input logic CLK,
    input logic rst_n,
    input logic find_setting,
    input logic led_red,
    input logic led_ir,
    input logic calib_done
);

    timeunit 1ns;
    timeprecision 1ps;

    // raised by any failing assertion below
    logic failed = 1'b0;

    // one LED at a time
    led_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
        !(led_red && led_ir))
        else begin
            $error("red and IR LEDs lit in the same cycle");
            failed = 1'b1;
        end

    // calib_done only clears through a restart strobe
    done_fall: assert property (@(posedge CLK) disable iff (!rst_n)
        $fell(calib_done) |-> $past(find_setting))
        else begin
            $error("calib_done fell without a find_setting strobe");
            failed = 1'b1;
        end

    reset_quiet: assert property (@(posedge CLK)
        !rst_n |-> (!led_red && !led_ir && !calib_done))
        else begin
            $error("LEDs or calib_done active during reset");
            failed = 1'b1;
        end

endmodule

bind oxi_controller oxi_chk u_oxi_chk (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .find_setting (find_setting),
    .led_red      (led_red),
    .led_ir       (led_ir),
    .calib_done   (calib_done)
);

//--- dv/oxi_tb.sv
module oxi_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUNS        = 8;
    localparam int CYCLE_LIMIT =
        RUNS * (4 * oxi_pkg::DC_MAX_WINDOWS * oxi_pkg::WINDOW_LEN + 400) + 2000;

    logic               CLK          = 1'b0;
    logic               rst_n        = 1'b1;
    logic               find_setting = 1'b0;
    oxi_pkg::adc_t      adc          = '0;
    logic               led_red;
    logic               led_ir;
    oxi_pkg::dc_comp_t  dc_comp;
    oxi_pkg::pga_gain_t pga_gain;
    oxi_pkg::adc_t      red_adc_value;
    oxi_pkg::adc_t      ir_adc_value;
    logic               calib_done;

    // plant parameters, redrawn for every calibration run
    int offset = 128;
    int amp    = 0;
    int cycle_cnt = 0;

    // reference model
    oxi_pkg::calib_state_t ref_state;
    int                    ref_win_cnt;
    int                    ref_win_sum;
    int                    ref_run_lo;
    int                    ref_run_hi;
    logic                  ref_win_done;
    int                    ref_avg;
    int                    ref_min;
    int                    ref_max;
    int                    ref_dc_tries;
    oxi_pkg::dc_comp_t     ref_dc;
    oxi_pkg::pga_gain_t    ref_gain;
    logic                  ref_try_red;
    logic                  ref_try_ir;
    oxi_pkg::dc_comp_t     ref_red_dc;
    oxi_pkg::dc_comp_t     ref_ir_dc;
    oxi_pkg::pga_gain_t    ref_red_gain;
    oxi_pkg::pga_gain_t    ref_ir_gain;
    logic                  ref_done;
    int                    ref_op_pos;
    logic                  exp_led_red;
    logic                  exp_led_ir;
    oxi_pkg::dc_comp_t     exp_dc;
    oxi_pkg::pga_gain_t    exp_gain;
    oxi_pkg::adc_t         exp_red_val;
    oxi_pkg::adc_t         exp_ir_val;

    oxi_controller dut (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .adc           (adc),
        .find_setting  (find_setting),
        .led_red       (led_red),
        .led_ir        (led_ir),
        .dc_comp       (dc_comp),
        .pga_gain      (pga_gain),
        .red_adc_value (red_adc_value),
        .ir_adc_value  (ir_adc_value),
        .calib_done    (calib_done)
    );

    always #10 CLK = ~CLK;

    task automatic fail_stop(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_stop($sformatf("Mismatch at %0d ns: %s is %0b, expected %0b",
                                $time, what, got, exp));
    endtask

    task automatic check_adc(input oxi_pkg::adc_t got, input oxi_pkg::adc_t exp,
                             input string what);
        if (got !== exp)
            fail_stop($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                                $time, what, got, exp));
    endtask

    task automatic check_dc(input oxi_pkg::dc_comp_t got, input oxi_pkg::dc_comp_t exp,
                            input string what);
        if (got !== exp)
            fail_stop($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                                $time, what, got, exp));
    endtask

    task automatic check_gain(input oxi_pkg::pga_gain_t got, input oxi_pkg::pga_gain_t exp,
                              input string what);
        if (got !== exp)
            fail_stop($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                                $time, what, got, exp));
    endtask

    // offset minus twice the dc code plus gain times ripple, clamped to the adc range
    function automatic oxi_pkg::adc_t plant_sample();
        int ripple;
        int level;
        ripple = int'($urandom_range(2 * amp)) - amp;
        level  = offset - 2 * int'(dc_comp) + int'(pga_gain) * ripple;
        if (level < 0)
            level = 0;
        else if (level > 255)
            level = 255;
        return oxi_pkg::adc_t'(level);
    endfunction

    task automatic model_reset();
        ref_state    = oxi_pkg::IDLE;
        ref_win_cnt  = 0;
        ref_win_sum  = 0;
        ref_run_lo   = 255;
        ref_run_hi   = 0;
        ref_win_done = 1'b0;
        ref_dc_tries = 0;
        ref_dc       = '0;
        ref_gain     = '0;
        ref_try_red  = 1'b0;
        ref_try_ir   = 1'b0;
        ref_red_dc   = '0;
        ref_ir_dc    = '0;
        ref_red_gain = '0;
        ref_ir_gain  = '0;
        ref_done     = 1'b0;
        ref_op_pos   = -1;
        exp_led_red  = 1'b0;
        exp_led_ir   = 1'b0;
        exp_dc       = '0;
        exp_gain     = '0;
        exp_red_val  = '0;
        exp_ir_val   = '0;
    endtask

    task automatic dc_search_step(input int avg);
        int code;
        code = int'(ref_dc);
        if ((avg >= oxi_pkg::AVG_LOW && avg <= oxi_pkg::AVG_HIGH) ||
            ref_dc_tries == oxi_pkg::DC_MAX_WINDOWS - 1) begin
            if (ref_state == oxi_pkg::DC_RED) begin
                ref_red_dc = ref_dc;
                ref_state  = oxi_pkg::GAIN_RED;
            end else begin
                ref_ir_dc = ref_dc;
                ref_state = oxi_pkg::GAIN_IR;
            end
            ref_gain     = '0;
            ref_dc_tries = 0;
        end else begin
            // too dark loses half the code, too bright gains half
            code = (avg < oxi_pkg::AVG_LOW) ? code - code / 2 : code + code / 2;
            if (code > 127)
                code = 127;
            ref_dc       = oxi_pkg::dc_comp_t'(code);
            ref_dc_tries = ref_dc_tries + 1;
        end
    endtask

    task automatic gain_search_step(input int lo, input int hi);
        logic               unclipped;
        oxi_pkg::pga_gain_t lock;
        unclipped = (lo > oxi_pkg::CLIP_LO) && (hi < oxi_pkg::CLIP_HI);
        if (unclipped && ref_gain < oxi_pkg::PGA_MAX) begin
            ref_gain = ref_gain + 1'b1;
        end else begin
            if (unclipped)
                lock = oxi_pkg::PGA_MAX;
            else
                lock = (ref_gain == 0) ? '0 : ref_gain - 1'b1;
            if (ref_state == oxi_pkg::GAIN_RED) begin
                ref_red_gain = lock;
                ref_state    = oxi_pkg::DC_IR;
                ref_dc       = oxi_pkg::DC_INIT;
                ref_try_red  = 1'b0;
                ref_try_ir   = 1'b1;
            end else begin
                ref_ir_gain = lock;
                ref_state   = oxi_pkg::OPERATE;
                ref_try_ir  = 1'b0;
                ref_done    = 1'b1;
            end
            ref_gain = '0;
        end
    endtask

    task automatic model_step();
        logic run;
        logic in_ir;
        logic done;
        int   avg;
        int   lo;
        int   hi;
        run  = ref_state inside {oxi_pkg::DC_RED, oxi_pkg::GAIN_RED,
                                 oxi_pkg::DC_IR, oxi_pkg::GAIN_IR};
        done = ref_win_done;
        avg  = ref_avg;
        lo   = ref_min;
        hi   = ref_max;

        // output stage works from last cycle's calibration registers
        if (ref_op_pos >= 0 && ref_op_pos % oxi_pkg::SLOT_LEN == oxi_pkg::SLOT_LEN - 1) begin
            if ((ref_op_pos / oxi_pkg::SLOT_LEN) % 2 == 1)
                exp_ir_val = adc;
            else
                exp_red_val = adc;
        end
        if (!ref_done) begin
            ref_op_pos  = -1;
            exp_led_red = ref_try_red;
            exp_led_ir  = ref_try_ir;
            exp_dc      = ref_dc;
            exp_gain    = ref_gain;
        end else begin
            ref_op_pos  = ref_op_pos + 1;
            in_ir       = ((ref_op_pos / oxi_pkg::SLOT_LEN) % 2 == 1);
            exp_led_red = !in_ir;
            exp_led_ir  = in_ir;
            exp_dc      = in_ir ? ref_ir_dc : ref_red_dc;
            exp_gain    = in_ir ? ref_ir_gain : ref_red_gain;
        end

        if (find_setting) begin
            ref_state    = oxi_pkg::START;
            ref_dc_tries = 0;
            ref_try_red  = 1'b0;
            ref_try_ir   = 1'b0;
            ref_dc       = oxi_pkg::DC_INIT;
            ref_gain     = '0;
            ref_done     = 1'b0;
        end else if (ref_state == oxi_pkg::START) begin
            ref_state   = oxi_pkg::DC_RED;
            ref_try_red = 1'b1;
        end else if (done && ref_state inside {oxi_pkg::DC_RED, oxi_pkg::DC_IR}) begin
            dc_search_step(avg);
        end else if (done && ref_state inside {oxi_pkg::GAIN_RED, oxi_pkg::GAIN_IR}) begin
            gain_search_step(lo, hi);
        end

        // 27-sample window statistics
        ref_win_done = 1'b0;
        if (!run) begin
            ref_win_cnt = 0;
            ref_win_sum = 0;
            ref_run_lo  = 255;
            ref_run_hi  = 0;
        end else begin
            ref_win_sum = ref_win_sum + int'(adc);
            ref_run_lo  = (int'(adc) < ref_run_lo) ? int'(adc) : ref_run_lo;
            ref_run_hi  = (int'(adc) > ref_run_hi) ? int'(adc) : ref_run_hi;
            ref_win_cnt = ref_win_cnt + 1;
            if (ref_win_cnt == oxi_pkg::WINDOW_LEN) begin
                ref_win_done = 1'b1;
                ref_avg      = ref_win_sum / oxi_pkg::WINDOW_LEN;
                ref_min      = ref_run_lo;
                ref_max      = ref_run_hi;
                ref_win_cnt  = 0;
                ref_win_sum  = 0;
                ref_run_lo   = 255;
                ref_run_hi   = 0;
            end
        end
    endtask

    always @(posedge CLK) begin
        if (!rst_n)
            model_reset();
        else
            model_step();
    end

    // outputs are settled by the falling edge
    always @(negedge CLK) begin
        check_bit(led_red, exp_led_red, "led_red");
        check_bit(led_ir, exp_led_ir, "led_ir");
        check_bit(calib_done, ref_done, "calib_done");
        check_dc(dc_comp, exp_dc, "dc_comp");
        check_gain(pga_gain, exp_gain, "pga_gain");
        check_adc(red_adc_value, exp_red_val, "red_adc_value");
        check_adc(ir_adc_value, exp_ir_val, "ir_adc_value");
    end

    // the bound checker flags its first failing assertion
    always @(posedge dut.u_oxi_chk.failed)
        fail_stop("an assertion in the bound checker failed");

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            fail_stop($sformatf("timeout: the run did not finish in %0d cycles", CYCLE_LIMIT));
    end

    task automatic step(input logic fs);
        @(posedge CLK);
        find_setting <= fs;
        adc          <= plant_sample();
    endtask

    // low offsets hit the window limit, high ones need the dc code raised
    task automatic pick_plant(input int run);
        case (run % 3)
            0:       offset = 60 + int'($urandom_range(60));
            1:       offset = 130 + int'($urandom_range(80));
            default: offset = 210 + int'($urandom_range(45));
        endcase
        amp = (run % 2 == 0) ? int'($urandom_range(2)) : 9 + int'($urandom_range(6));
    endtask

    initial begin
        int run;
        void'($urandom(2908));
        // clean reset edge just after time zero
        #1;
        rst_n = 1'b0;
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        repeat (8) step(1'b0);

        for (run = 0; run < RUNS; run++) begin
            pick_plant(run);
            step(1'b1);
            step(1'b0);
            if (run % 3 == 2) begin
                // next strobe lands mid-search or early in operation
                repeat (100 + $urandom_range(1200)) step(1'b0);
            end else begin
                while (!calib_done)
                    step(1'b0);
                repeat (200 + $urandom_range(199)) step(1'b0);
            end
        end

        @(negedge CLK);
        #1;
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- all.f
src/oxi_pkg.sv
src/window_stats.sv
src/calib_fsm.sv
src/led_sequencer.sv
src/oxi_controller.sv
dv/oxi_chk.sv
dv/oxi_tb.sv

//--- Bender.yml
package:
  name: oxi_controller

sources:
  - src/oxi_pkg.sv
  - src/window_stats.sv
  - src/calib_fsm.sv
  - src/led_sequencer.sv
  - src/oxi_controller.sv
  - target: test
    files:
      - dv/oxi_chk.sv
      - dv/oxi_tb.sv
